// ==== verilog/frontend_config.svh ====
`ifndef FRONTEND_CONFIG_SVH
`define FRONTEND_CONFIG_SVH

// First fetch address once reset is released.
`define RESET_PC 32'h8000_0000

// Entries in the instruction queue.
// Must stay a power of two, the pointers wrap on their top bit.
`define QUEUE_DEPTH 4

`endif

// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // Raw instruction word.
  typedef logic [31:0] inst_t;

  // Architectural register index, x0 to x31.
  typedef logic [4:0] reg_idx_t;

  typedef logic [2:0] funct3_t;

  // Immediate after sign or zero extension.
  typedef logic [31:0] imm_t;

  // Base opcodes handled by the decoder, standard RV32I encodings.
  typedef enum logic [6:0] {
    LOAD   = 7'b0000011,
    OP_IMM = 7'b0010011,
    AUIPC  = 7'b0010111,
    STORE  = 7'b0100011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011,
    JALR   = 7'b1100111,
    JAL    = 7'b1101111,
    SYSTEM = 7'b1110011
  } opcode_e;

  // Immediate layout selected from the opcode.
  typedef enum logic [2:0] {
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J
  } format_e;

endpackage

// ==== verilog/pipe_pkg.sv ====
package pipe_pkg;

  `include "frontend_config.svh"

  // Byte address of an instruction.
  typedef logic [31:0] pc_t;

  // Index bits into the queue storage.
  localparam int QPTR_W = $clog2(`QUEUE_DEPTH);

  // Queue pointer, index bits plus one wrap bit on top.
  typedef logic [QPTR_W:0] qptr_t;

endpackage

// ==== verilog/fetch_if.sv ====
`timescale 1ns/1ps

// One pc and instruction pair moving between two stages.
interface fetch_if;

  logic               valid;
  logic               ready;
  pipe_pkg::pc_t      pc;
  rv_isa_pkg::inst_t  inst;

  modport producer (
    output valid,
    output pc,
    output inst,
    input  ready
  );

  modport consumer (
    input  valid,
    input  pc,
    input  inst,
    output ready
  );

endinterface

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps

`include "frontend_config.svh"

module fetch_unit (
  input  logic               clock,
  input  logic               reset,
  input  logic               redirect,
  input  pipe_pkg::pc_t      redirect_target,
  output pipe_pkg::pc_t      imem_addr,
  input  rv_isa_pkg::inst_t  imem_data,
  fetch_if.producer          out
);

  pipe_pkg::pc_t pc_q;
  logic          valid_q;
  logic          xfer;

  // A redirect cancels whatever handshake happens in the same cycle.
  assign xfer = out.valid && out.ready && !redirect;

  // Valid rises on the first cycle after reset and stays up.
  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q <= `RESET_PC;
    end else if (redirect) begin
      pc_q <= redirect_target; // Jump wins over advance.
    end else if (xfer) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // Memory is read combinationally at the current pc.
  assign imem_addr = pc_q;

  assign out.valid = valid_q;
  assign out.pc    = pc_q;
  assign out.inst  = imem_data; // Stable while stalled, address is held.

  a_pc_aligned: assert property (
    @(posedge clock) disable iff (reset)
    pc_q[1:0] == 2'b00
  ) else $error("fetch pc not word aligned: %h", pc_q);

endmodule

// ==== verilog/inst_queue.sv ====
`timescale 1ns/1ps

`include "frontend_config.svh"

module inst_queue (
  input  logic       clock,
  input  logic       reset,
  input  logic       flush,
  fetch_if.consumer  in,
  fetch_if.producer  out
);

  localparam int IDX_W = pipe_pkg::QPTR_W;

  // Live entries lie between rd_ptr and wr_ptr.
  pipe_pkg::pc_t     pc_mem   [`QUEUE_DEPTH];
  rv_isa_pkg::inst_t inst_mem [`QUEUE_DEPTH];

  pipe_pkg::qptr_t   wr_ptr;
  pipe_pkg::qptr_t   rd_ptr;

  logic              full;
  logic              empty;
  logic              wr_en;
  logic              rd_en;

  // Same index on a different lap means every slot is taken.
  assign full  = (wr_ptr[IDX_W] != rd_ptr[IDX_W]) &&
                 (wr_ptr[IDX_W-1:0] == rd_ptr[IDX_W-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  assign in.ready  = !full;
  assign out.valid = !empty;

  // Nothing moves in a flush cycle.
  assign wr_en = in.valid && in.ready && !flush;
  assign rd_en = out.valid && out.ready && !flush;

  always_ff @(posedge clock) begin
    if (wr_en) begin
      pc_mem[wr_ptr[IDX_W-1:0]]   <= in.pc;
      inst_mem[wr_ptr[IDX_W-1:0]] <= in.inst;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      wr_ptr <= '0;
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      rd_ptr <= '0;
    end else if (rd_en) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Head entry is visible the cycle after it was written.
  assign out.pc   = pc_mem[rd_ptr[IDX_W-1:0]];
  assign out.inst = inst_mem[rd_ptr[IDX_W-1:0]];

  a_no_write_full: assert property (
    @(posedge clock) disable iff (reset)
    full && !flush |=> $stable(wr_ptr)
  ) else $error("queue written while full");

  a_no_read_empty: assert property (
    @(posedge clock) disable iff (reset)
    empty && !flush |=> $stable(rd_ptr)
  ) else $error("queue read while empty");

endmodule

// ==== verilog/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 flush,
  fetch_if.consumer            in,
  output logic                 dec_valid,
  input  logic                 dec_ready,
  output pipe_pkg::pc_t        dec_pc,
  output rv_isa_pkg::opcode_e  dec_opcode,
  output rv_isa_pkg::funct3_t  dec_funct3,
  output rv_isa_pkg::reg_idx_t dec_rs1,
  output rv_isa_pkg::reg_idx_t dec_rs2,
  output rv_isa_pkg::reg_idx_t dec_rd,
  output rv_isa_pkg::imm_t     dec_imm,
  output logic                 dec_reg_wen
);

  logic                full_q;
  rv_isa_pkg::inst_t   inst_q;
  pipe_pkg::pc_t       pc_q;
  logic                take;

  rv_isa_pkg::opcode_e opcode;
  rv_isa_pkg::format_e fmt;
  logic                fmt_known;

  // Free slot, or the held item leaves in this same cycle.
  assign in.ready = !full_q || dec_ready;
  assign take     = in.valid && in.ready && !flush;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      full_q <= 1'b0;
    end else if (take) begin
      full_q <= 1'b1;
    end else if (dec_ready) begin
      full_q <= 1'b0; // Drained with nothing behind it.
    end
  end

  always_ff @(posedge clock) begin
    if (take) begin
      inst_q <= in.inst;
      pc_q   <= in.pc;
    end
  end

  assign dec_valid = full_q;
  assign dec_pc    = pc_q;

  // Fixed field positions.
  assign opcode     = rv_isa_pkg::opcode_e'(inst_q[6:0]);
  assign dec_opcode = opcode;
  assign dec_funct3 = inst_q[14:12];
  assign dec_rd     = inst_q[11:7];
  assign dec_rs1    = inst_q[19:15];
  assign dec_rs2    = inst_q[24:20];

  // Stores and branches have no destination register.
  assign dec_reg_wen = !(opcode == rv_isa_pkg::STORE || opcode == rv_isa_pkg::BRANCH);

  always_comb begin
    fmt_known = 1'b1;
    fmt       = rv_isa_pkg::FMT_R;
    case (opcode)
      rv_isa_pkg::OP:     fmt = rv_isa_pkg::FMT_R;
      rv_isa_pkg::LOAD,
      rv_isa_pkg::OP_IMM,
      rv_isa_pkg::JALR,
      rv_isa_pkg::SYSTEM: fmt = rv_isa_pkg::FMT_I; // CSR number sits in the I field.
      rv_isa_pkg::STORE:  fmt = rv_isa_pkg::FMT_S;
      rv_isa_pkg::BRANCH: fmt = rv_isa_pkg::FMT_B;
      rv_isa_pkg::LUI,
      rv_isa_pkg::AUIPC:  fmt = rv_isa_pkg::FMT_U;
      rv_isa_pkg::JAL:    fmt = rv_isa_pkg::FMT_J;
      default:            fmt_known = 1'b0;
    endcase
  end

  always_comb begin
    dec_imm = '0;
    if (fmt_known) begin
      case (fmt)
        rv_isa_pkg::FMT_I: dec_imm = {{20{inst_q[31]}}, inst_q[31:20]};
        rv_isa_pkg::FMT_S: dec_imm = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
        rv_isa_pkg::FMT_B: begin
          dec_imm = {{19{inst_q[31]}}, inst_q[31], inst_q[7],
                     inst_q[30:25], inst_q[11:8], 1'b0};
        end
        rv_isa_pkg::FMT_U: dec_imm = {inst_q[31:12], 12'b0};
        rv_isa_pkg::FMT_J: begin
          dec_imm = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12],
                     inst_q[20], inst_q[30:21], 1'b0};
        end
        // R type carries funct7 zero extended.
        default:           dec_imm = {25'b0, inst_q[31:25]};
      endcase
    end
  end

  // A stalled output must not change until it is accepted.
  a_hold_on_stall: assert property (
    @(posedge clock) disable iff (reset)
    dec_valid && !dec_ready && !flush |=> dec_valid && $stable(inst_q) && $stable(pc_q)
  ) else $error("decode output changed while stalled");

endmodule

// ==== verilog/rv_frontend.sv ====
`timescale 1ns/1ps

module rv_frontend (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 redirect,
  input  pipe_pkg::pc_t        redirect_target,
  output pipe_pkg::pc_t        imem_addr,
  input  rv_isa_pkg::inst_t    imem_data,
  output logic                 dec_valid,
  input  logic                 dec_ready,
  output pipe_pkg::pc_t        dec_pc,
  output rv_isa_pkg::opcode_e  dec_opcode,
  output rv_isa_pkg::funct3_t  dec_funct3,
  output rv_isa_pkg::reg_idx_t dec_rs1,
  output rv_isa_pkg::reg_idx_t dec_rs2,
  output rv_isa_pkg::reg_idx_t dec_rd,
  output rv_isa_pkg::imm_t     dec_imm,
  output logic                 dec_reg_wen
);

  // Links between the stages.
  fetch_if fetch_to_queue ();
  fetch_if queue_to_decode ();

  fetch_unit i_fetch_unit (
    .clock           (clock),
    .reset           (reset),
    .redirect        (redirect),
    .redirect_target (redirect_target),
    .imem_addr       (imem_addr),
    .imem_data       (imem_data),
    .out             (fetch_to_queue.producer)
  );

  // Redirect doubles as the flush for everything in flight.
  inst_queue i_inst_queue (
    .clock (clock),
    .reset (reset),
    .flush (redirect),
    .in    (fetch_to_queue.consumer),
    .out   (queue_to_decode.producer)
  );

  decode_unit i_decode_unit (
    .clock       (clock),
    .reset       (reset),
    .flush       (redirect),
    .in          (queue_to_decode.consumer),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec_pc      (dec_pc),
    .dec_opcode  (dec_opcode),
    .dec_funct3  (dec_funct3),
    .dec_rs1     (dec_rs1),
    .dec_rs2     (dec_rs2),
    .dec_rd      (dec_rd),
    .dec_imm     (dec_imm),
    .dec_reg_wen (dec_reg_wen)
  );

endmodule

// ==== testbench/tb_decode_model.svh ====
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// Immediate built straight from the RV32I format tables.
function automatic rv_isa_pkg::imm_t expected_imm(input rv_isa_pkg::inst_t word);
  logic [11:0] i_imm;
  logic [11:0] s_imm;
  logic [12:0] b_imm;
  logic [20:0] j_imm;
  rv_isa_pkg::imm_t imm;
  i_imm = word[31:20];
  s_imm = {word[31:25], word[11:7]};
  b_imm = {word[31], word[7], word[30:25], word[11:8], 1'b0};
  j_imm = {word[31], word[19:12], word[20], word[30:21], 1'b0};
  case (word[6:0])
    rv_isa_pkg::LOAD, rv_isa_pkg::OP_IMM,
    rv_isa_pkg::JALR, rv_isa_pkg::SYSTEM: imm = 32'($signed(i_imm));
    rv_isa_pkg::STORE:                    imm = 32'($signed(s_imm));
    rv_isa_pkg::BRANCH:                   imm = 32'($signed(b_imm));
    rv_isa_pkg::JAL:                      imm = 32'($signed(j_imm));
    rv_isa_pkg::LUI, rv_isa_pkg::AUIPC:   imm = {word[31:12], 12'h000};
    rv_isa_pkg::OP:                       imm = {25'b0, word[31:25]}; // funct7, unsigned.
    default:                              imm = '0;
  endcase
  return imm;
endfunction

// Only stores and branches leave rd untouched.
function automatic logic expected_wen(input rv_isa_pkg::opcode_e op);
  case (op)
    rv_isa_pkg::STORE, rv_isa_pkg::BRANCH: return 1'b0;
    default:                               return 1'b1;
  endcase
endfunction

task automatic count_error();
  test_errors++;
  total_errors++;
endtask

task automatic report_problem(input string what);
  $display("ERROR in %s: %s", test_name, what);
  count_error();
endtask

task automatic check_pc(input pipe_pkg::pc_t exp, input pipe_pkg::pc_t act);
  checks++;
  if (act !== exp) begin
    $display("CHECK FAILED %s pc: expected %h actual %h", test_name, exp, act);
    count_error();
  end
endtask

task automatic check_opcode(input rv_isa_pkg::opcode_e exp, input rv_isa_pkg::opcode_e act);
  checks++;
  if (act !== exp) begin
    $display("CHECK FAILED %s opcode: expected %s (%h) actual %s (%h)",
             test_name, exp.name(), exp, act.name(), act);
    count_error();
  end
endtask

task automatic check_field(input string field, input rv_isa_pkg::reg_idx_t exp,
                           input rv_isa_pkg::reg_idx_t act);
  checks++;
  if (act !== exp) begin
    $display("CHECK FAILED %s %s: expected %0d actual %0d", test_name, field, exp, act);
    count_error();
  end
endtask

task automatic check_funct3(input rv_isa_pkg::funct3_t exp, input rv_isa_pkg::funct3_t act);
  checks++;
  if (act !== exp) begin
    $display("CHECK FAILED %s funct3: expected %b actual %b", test_name, exp, act);
    count_error();
  end
endtask

task automatic check_imm(input rv_isa_pkg::imm_t exp, input rv_isa_pkg::imm_t act);
  checks++;
  if (act !== exp) begin
    $display("CHECK FAILED %s imm: expected %h actual %h", test_name, exp, act);
    count_error();
  end
endtask

task automatic check_wen(input logic exp, input logic act);
  checks++;
  if (act !== exp) begin
    $display("CHECK FAILED %s reg_wen: expected %b actual %b", test_name, exp, act);
    count_error();
  end
endtask

`endif

// ==== testbench/tb_rv_frontend.sv ====
`timescale 1ns/1ps

`include "frontend_config.svh"

module tb_rv_frontend;

  localparam int MEM_WORDS      = 256;
  localparam int RESET_CYCLES   = 10;
  localparam int STIM_CYCLES    = 750; // Rough sum of all test phases.
  localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;
  localparam int SEED           = 32'h5742;

  logic                 clock;
  logic                 reset;
  logic                 redirect;
  pipe_pkg::pc_t        redirect_target;
  pipe_pkg::pc_t        imem_addr;
  rv_isa_pkg::inst_t    imem_data;
  logic                 dec_valid;
  logic                 dec_ready;
  pipe_pkg::pc_t        dec_pc;
  rv_isa_pkg::opcode_e  dec_opcode;
  rv_isa_pkg::funct3_t  dec_funct3;
  rv_isa_pkg::reg_idx_t dec_rs1;
  rv_isa_pkg::reg_idx_t dec_rs2;
  rv_isa_pkg::reg_idx_t dec_rd;
  rv_isa_pkg::imm_t     dec_imm;
  logic                 dec_reg_wen;

  rv_isa_pkg::inst_t    mem [MEM_WORDS]; // Word 0 sits at RESET_PC.

  string                test_name;
  int                   test_errors;
  int                   total_errors;
  int                   checks;
  int                   tests_run;
  int                   tests_failed;
  int                   transfers;
  int                   redirects_seen;
  int                   cycle_count;
  pipe_pkg::pc_t        expected_pc;
  pipe_pkg::pc_t        fetch_target;
  bit                   fetch_target_pending;
  bit                   opcode_seen [128];

  `include "tb_decode_model.svh"

  rv_frontend i_rv_frontend (
    .clock           (clock),
    .reset           (reset),
    .redirect        (redirect),
    .redirect_target (redirect_target),
    .imem_addr       (imem_addr),
    .imem_data       (imem_data),
    .dec_valid       (dec_valid),
    .dec_ready       (dec_ready),
    .dec_pc          (dec_pc),
    .dec_opcode      (dec_opcode),
    .dec_funct3      (dec_funct3),
    .dec_rs1         (dec_rs1),
    .dec_rs2         (dec_rs2),
    .dec_rd          (dec_rd),
    .dec_imm         (dec_imm),
    .dec_reg_wen     (dec_reg_wen)
  );

  // Addresses past the model wrap around its 256 words.
  function automatic logic [7:0] word_index(input pipe_pkg::pc_t addr);
    pipe_pkg::pc_t offset;
    offset = addr - `RESET_PC;
    return offset[9:2];
  endfunction

  assign imem_data = mem[word_index(imem_addr)];

  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic rv_isa_pkg::opcode_e random_opcode();
    rv_isa_pkg::opcode_e op;
    int steps;
    op = op.first();
    steps = $urandom % op.num();
    repeat (steps) op = op.next();
    return op;
  endfunction

  task automatic fill_memory();
    rv_isa_pkg::inst_t word;
    for (int i = 0; i < MEM_WORDS; i++) begin
      word      = $urandom;
      word[6:0] = random_opcode(); // Upper bits stay random.
      mem[i]    = word;
    end
  endtask

  // Looks at the edge that just happened, before any new drive lands.
  task automatic observe_edge();
    rv_isa_pkg::inst_t   word;
    rv_isa_pkg::opcode_e op;
    if (fetch_target_pending) begin
      check_pc(fetch_target, imem_addr); // Fetch restarts at the jump target.
      fetch_target_pending = 1'b0;
    end
    if (redirect) begin
      expected_pc = redirect_target; // Anything older is flushed.
      fetch_target = redirect_target;
      fetch_target_pending = 1'b1;
      redirects_seen++;
    end else if (dec_valid && dec_ready) begin
      word = mem[word_index(expected_pc)];
      op   = rv_isa_pkg::opcode_e'(word[6:0]);
      check_pc(expected_pc, dec_pc);
      check_opcode(op, dec_opcode);
      check_funct3(word[14:12], dec_funct3);
      check_field("rs1", word[19:15], dec_rs1);
      check_field("rs2", word[24:20], dec_rs2);
      check_field("rd", word[11:7], dec_rd);
      check_imm(expected_imm(word), dec_imm);
      check_wen(expected_wen(op), dec_reg_wen);
      opcode_seen[word[6:0]] = 1'b1;
      expected_pc = expected_pc + 32'd4;
      transfers++;
    end
  endtask

  task automatic step(input bit random_ready, input bit allow_redirect);
    pipe_pkg::pc_t target;
    @(posedge clock);
    observe_edge();
    if (random_ready) begin
      dec_ready <= (($urandom % 3) != 0); // Low about a third of the time.
    end else begin
      dec_ready <= 1'b1;
    end
    if (allow_redirect && (($urandom % 40) == 0)) begin
      target = `RESET_PC + (($urandom % MEM_WORDS) << 2);
      redirect        <= 1'b1;
      redirect_target <= target;
    end else begin
      redirect <= 1'b0;
    end
  endtask

  task automatic run_transfers(input int count, input bit random_ready, input bit allow_redirect);
    int goal;
    goal = transfers + count;
    while (transfers < goal) step(random_ready, allow_redirect);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errors != 0) tests_failed++;
    $display("Test %-14s done: %0d errors, %0d transfers so far",
             test_name, test_errors, transfers);
  endtask

  task automatic check_opcode_coverage();
    rv_isa_pkg::opcode_e op;
    op = op.first();
    repeat (op.num()) begin
      if (!opcode_seen[op]) report_problem($sformatf("opcode %s never reached decode", op.name()));
      op = op.next();
    end
  endtask

  initial begin
    int redirects_before;
    clock                = 1'b0;
    reset                = 1'b1;
    redirect             = 1'b0;
    redirect_target      = '0;
    dec_ready            = 1'b0;
    test_errors          = 0;
    total_errors         = 0;
    checks               = 0;
    tests_run            = 0;
    tests_failed         = 0;
    transfers            = 0;
    redirects_seen       = 0;
    cycle_count          = 0;
    expected_pc          = `RESET_PC;
    fetch_target         = '0;
    fetch_target_pending = 1'b0;
    void'($urandom(SEED));
    fill_memory();

    start_test("reset");
    repeat (RESET_CYCLES) begin
      @(negedge clock);
      if (dec_valid !== 1'b0) report_problem("dec_valid was not low during reset");
      check_pc(`RESET_PC, imem_addr);
    end
    @(posedge clock);
    reset     <= 1'b0;
    dec_ready <= 1'b1;
    run_transfers(1, 1'b0, 1'b0); // First output must carry RESET_PC.
    finish_test();

    start_test("stream_order");
    run_transfers(100, 1'b0, 1'b0);
    finish_test();

    start_test("decode_fields");
    run_transfers(100, 1'b0, 1'b0);
    check_opcode_coverage();
    finish_test();

    start_test("reg_write_flag");
    run_transfers(60, 1'b0, 1'b0);
    finish_test();

    start_test("back_pressure");
    run_transfers(150, 1'b1, 1'b0);
    finish_test();

    start_test("redirect_flush");
    redirects_before = redirects_seen;
    run_transfers(120, 1'b1, 1'b1);
    if (redirects_seen == redirects_before) report_problem("no redirect was issued");
    finish_test();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, total_errors);
    if (total_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== rv_frontend.f ====
+incdir+verilog
+incdir+testbench
verilog/rv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/fetch_if.sv
verilog/fetch_unit.sv
verilog/inst_queue.sv
verilog/decode_unit.sv
verilog/rv_frontend.sv
testbench/tb_rv_frontend.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_frontend
FILELIST  ?= rv_frontend.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verilog/*.svh testbench/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
